//--- Makefile
# Verilator simulation of the load/store slot unit

VERILATOR ?= verilator
TOP       ?= mem_unit_tb
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

.PHONY: sim clean

# Build, run, and succeed only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- mem_ram.sv
`timescale 1ns/1ps
`default_nettype none

module mem_ram import mem_unit_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_i,
	input  logic      cmd_valid_i,
	input  ram_cmd_t  cmd_i,
	output logic      ack_o,
	output slot_idx_t ack_slot_o,
	output mem_data_t rdata_o
);

	// ==================================================
	// Storage
	// ==================================================

	mem_data_t mem_q [MEM_WORDS];

	// A store lands in the array on the issue edge
	always_ff @(posedge clk_i) begin
		if (cmd_valid_i && cmd_i.is_store) begin
			mem_q[cmd_i.addr] <= cmd_i.wdata;
		end
	end

	// ==================================================
	// Response pipeline
	// ==================================================

	// Stage zero is loaded on the issue edge, so the last stage is seen
	// exactly MEM_LATENCY cycles after the command
	logic      valid_q [MEM_LATENCY];
	slot_idx_t slot_q [MEM_LATENCY];
	mem_data_t data_q [MEM_LATENCY];

	// Only the valid bits need a reset
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int k = 0; k < MEM_LATENCY; k++) begin
				valid_q[k] <= 1'b0;
			end
		end else begin
			valid_q[0] <= cmd_valid_i;
			for (int k = 1; k < MEM_LATENCY; k++) begin
				valid_q[k] <= valid_q[k-1];
			end
		end
	end

	// A load samples the word as it was before this edge
	always_ff @(posedge clk_i) begin
		slot_q[0] <= cmd_i.slot;
		data_q[0] <= mem_q[cmd_i.addr];
		for (int k = 1; k < MEM_LATENCY; k++) begin
			slot_q[k] <= slot_q[k-1];
			data_q[k] <= data_q[k-1];
		end
	end

	assign ack_o = valid_q[MEM_LATENCY-1];
	assign ack_slot_o = slot_q[MEM_LATENCY-1];
	assign rdata_o = data_q[MEM_LATENCY-1];

endmodule

`default_nettype wire

//--- mem_slot_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mem_slot_ctrl import mem_unit_pkg::*; (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 req_i,
	input  logic                 flush_i,
	input  logic                 ram_ack_i,
	input  slot_idx_t            ram_ack_slot_i,
	input  slot_state_t          slot_state_i [NUM_SLOTS],
	input  mem_req_t             slot_entry_i [NUM_SLOTS],
	input  mem_data_t            slot_rdata_i [NUM_SLOTS],
	output logic [NUM_SLOTS-1:0] set_ready_o,
	output logic [NUM_SLOTS-1:0] set_avail_o,
	output logic [NUM_SLOTS-1:0] slot_ack_o,
	output logic                 wr_en_o,
	output logic                 cap_en_o,
	output slot_idx_t            wr_slot_o,
	output slot_idx_t            cap_slot_o,
	output logic                 ram_cmd_valid_o,
	output ram_cmd_t             ram_cmd_o,
	output logic                 ready_o,
	output logic                 done_o,
	output mem_res_t             done_data_o
);

	// Circular pointer step over the issue queue
	function automatic slot_idx_t next_ptr(slot_idx_t p);
		if (p == slot_idx_t'(NUM_SLOTS - 1)) begin
			return '0;
		end
		return p + slot_idx_t'(1);
	endfunction

	// ==================================================
	// Slot allocation and completion search
	// ==================================================

	slot_idx_t alloc_idx;
	slot_idx_t delay_idx;
	logic      any_avail;
	logic      any_delay;
	logic      accept;

	// Scan from the top down so the lowest matching slot is kept
	always_comb begin
		alloc_idx = '0;
		delay_idx = '0;
		any_avail = 1'b0;
		any_delay = 1'b0;
		for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
			if (slot_state_i[i] == SLOT_AVAIL) begin
				alloc_idx = slot_idx_t'(i);
				any_avail = 1'b1;
			end
			// Only one slot can be in delay since the RAM serves one access at a time
			if (slot_state_i[i] == SLOT_DELAY) begin
				delay_idx = slot_idx_t'(i);
				any_delay = 1'b1;
			end
		end
	end

	assign ready_o = any_avail;
	// A request in the flush cycle is thrown away
	assign accept = req_i && any_avail && !flush_i;

	assign wr_en_o = accept;
	assign wr_slot_o = alloc_idx;
	assign set_ready_o = accept ? (NUM_SLOTS'(1) << alloc_idx) : '0;
	assign set_avail_o = {NUM_SLOTS{flush_i}};

	// ==================================================
	// Issue queue and RAM tracking
	// ==================================================

	slot_idx_t      queue_q [NUM_SLOTS];
	slot_idx_t      head_q;
	slot_idx_t      tail_q;
	logic [SLOT_W:0] queue_cnt_q;
	logic           ram_busy_q;
	logic           drop_q;
	slot_idx_t      head_slot;
	logic           issue;
	logic           ack_ok;

	assign head_slot = queue_q[head_q];
	// The head goes out as soon as it is active and nothing is in flight
	assign issue = (queue_cnt_q != '0) && (slot_state_i[head_slot] == SLOT_ACTIVE) &&
		!ram_busy_q && !flush_i;

	assign ram_cmd_valid_o = issue;
	assign ram_cmd_o.is_store = slot_entry_i[head_slot].is_store;
	assign ram_cmd_o.addr = slot_entry_i[head_slot].addr;
	assign ram_cmd_o.wdata = slot_entry_i[head_slot].wdata;
	assign ram_cmd_o.slot = head_slot;

	// Slot indices in acceptance order, no reset needed on the storage
	always_ff @(posedge clk_i) begin
		if (accept) begin
			queue_q[tail_q] <= alloc_idx;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i || flush_i) begin
			head_q <= '0;
			tail_q <= '0;
			queue_cnt_q <= '0;
		end else begin
			if (accept) begin
				tail_q <= next_ptr(tail_q);
			end
			if (issue) begin
				head_q <= next_ptr(head_q);
			end
			case ({accept, issue})
				2'b10: queue_cnt_q <= queue_cnt_q + (SLOT_W + 1)'(1);
				2'b01: queue_cnt_q <= queue_cnt_q - (SLOT_W + 1)'(1);
				default: queue_cnt_q <= queue_cnt_q;
			endcase
		end
	end

	// Busy stays up through a flush so a stale ack still frees the RAM
	// The drop flag marks that the ack in flight belongs to a flushed slot
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ram_busy_q <= 1'b0;
			drop_q <= 1'b0;
		end else begin
			if (issue) begin
				ram_busy_q <= 1'b1;
			end else if (ram_ack_i) begin
				ram_busy_q <= 1'b0;
			end
			if (ram_ack_i) begin
				drop_q <= 1'b0;
			end else if (flush_i && ram_busy_q) begin
				drop_q <= 1'b1;
			end
		end
	end

	// ==================================================
	// Ack routing and done
	// ==================================================

	assign ack_ok = ram_ack_i && !drop_q && (slot_state_i[ram_ack_slot_i] == SLOT_ACTIVE);
	assign slot_ack_o = ack_ok ? (NUM_SLOTS'(1) << ram_ack_slot_i) : '0;
	assign cap_en_o = ack_ok;
	assign cap_slot_o = ram_ack_slot_i;

	// Done follows the delay cycle of the finishing slot
	// Stores report zero read data
	assign done_o = any_delay;
	assign done_data_o.is_load = !slot_entry_i[delay_idx].is_store;
	assign done_data_o.tag = slot_entry_i[delay_idx].tag;
	assign done_data_o.rdata = slot_entry_i[delay_idx].is_store ? '0 : slot_rdata_i[delay_idx];

endmodule

`default_nettype wire

//--- mem_slot_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mem_slot_regs import mem_unit_pkg::*; (
	input  logic      clk_i,
	input  logic      wr_en_i,
	input  slot_idx_t wr_slot_i,
	input  mem_req_t  req_data_i,
	input  logic      cap_en_i,
	input  slot_idx_t cap_slot_i,
	input  mem_data_t cap_data_i,
	output mem_req_t  entry_o [NUM_SLOTS],
	output mem_data_t rdata_o [NUM_SLOTS]
);

	// ==================================================
	// Request entries
	// ==================================================

	// Each slot keeps the request it was given until it is reused
	// The tracker state tells whether the entry is live
	mem_req_t  entry_q [NUM_SLOTS];
	mem_data_t rdata_q [NUM_SLOTS];

	always_ff @(posedge clk_i) begin
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if (wr_en_i && (wr_slot_i == slot_idx_t'(s))) begin
				entry_q[s] <= req_data_i;
			end
		end
	end

	// ==================================================
	// Read data capture
	// ==================================================

	// Load data lands here on the ack from the RAM
	// A store also writes this word but its result masks it out
	always_ff @(posedge clk_i) begin
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if (cap_en_i && (cap_slot_i == slot_idx_t'(s))) begin
				rdata_q[s] <= cap_data_i;
			end
		end
	end

	// Both arrays are visible to the control module at all times
	always_comb begin
		for (int s = 0; s < NUM_SLOTS; s++) begin
			entry_o[s] = entry_q[s];
			rdata_o[s] = rdata_q[s];
		end
	end

endmodule

`default_nettype wire

//--- mem_slot_state.sv
`timescale 1ns/1ps
`default_nettype none

module mem_slot_state import mem_unit_pkg::*; (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        ack_i,
	input  logic        set_ready_i,
	input  logic        set_avail_i,
	output slot_state_t state_o
);

	// One tracker per slot
	// A freshly allocated slot spends one cycle in ready, then waits in active
	// until the RAM acknowledges it, then spends one cycle in delay while the
	// done pulse is out
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_o <= SLOT_AVAIL;
		end else begin
			case (state_o)
				SLOT_AVAIL: state_o <= SLOT_AVAIL;
				SLOT_READY: state_o <= SLOT_ACTIVE;
				SLOT_ACTIVE: begin
					if (ack_i) begin
						state_o <= SLOT_DELAY;
					end
				end
				SLOT_DELAY: state_o <= SLOT_AVAIL;
				default: state_o <= SLOT_AVAIL;
			endcase
			// Allocation overrides the normal step
			if (set_ready_i) begin
				state_o <= SLOT_READY;
			end
			// Flush wins over everything else
			if (set_avail_i) begin
				state_o <= SLOT_AVAIL;
			end
		end
	end

endmodule

`default_nettype wire

//--- mem_unit_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mem_unit_asserts (
	input logic clk_i,
	input logic rst_i,
	input logic flush_i,
	input logic ready_i,
	input logic done_i
);

	// Running count of failed assertions
	int err_cnt;

	initial err_cnt = 0;

	// ==================================================
	// Top-level protocol checks
	// ==================================================

	// No completion may start while the unit is held in reset
	a_no_done_in_reset: assert property (
		@(posedge clk_i) rst_i |-> !$rose(done_i)
	) else begin
		err_cnt++;
		$error("done_o rose while rst_i was high");
	end

	// The RAM serves one access at a time, so two done pulses never touch
	a_done_single: assert property (
		@(posedge clk_i) disable iff (rst_i) done_i |=> !done_i
	) else begin
		err_cnt++;
		$error("done_o high on two consecutive cycles");
	end

	// With every slot busy only a completion or a flush can free one
	a_ready_held_low: assert property (
		@(posedge clk_i) disable iff (rst_i)
		(!ready_i && !done_i && !flush_i) |=> !ready_i
	) else begin
		err_cnt++;
		$error("ready_o rose without a done_o or a flush_i");
	end

endmodule

`default_nettype wire

//--- mem_unit_pkg.sv
`default_nettype none

package mem_unit_pkg;

	// ==================================================
	// Sizes
	// ==================================================

	// Number of request slots held by the unit
	localparam int NUM_SLOTS = 2;
	// Cycles from a RAM issue to the matching ack
	localparam int MEM_LATENCY = 3;

	localparam int ADDR_W = 4;
	localparam int DATA_W = 32;
	localparam int TAG_W = 4;

	// Enough bits to name one slot, never less than one
	localparam int SLOT_W = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;
	// Depth of the word RAM follows from the address width
	localparam int MEM_WORDS = 1 << ADDR_W;

	// ==================================================
	// Types
	// ==================================================

	typedef logic [ADDR_W-1:0] mem_addr_t;
	typedef logic [DATA_W-1:0] mem_data_t;
	typedef logic [TAG_W-1:0] mem_tag_t;
	typedef logic [SLOT_W-1:0] slot_idx_t;

	// Life cycle of one slot, stepped by its own tracker
	typedef enum logic [1:0] {
		SLOT_AVAIL  = 2'd0,
		SLOT_READY  = 2'd1,
		SLOT_ACTIVE = 2'd2,
		SLOT_DELAY  = 2'd3
	} slot_state_t;

	// Request as it arrives from the requester, 41 bits
	typedef struct packed {
		logic      is_store;
		mem_addr_t addr;
		mem_data_t wdata;
		mem_tag_t  tag;
	} mem_req_t;

	// Completion payload that travels with the done pulse, 37 bits
	typedef struct packed {
		logic      is_load;
		mem_tag_t  tag;
		mem_data_t rdata;
	} mem_res_t;

	// Command from the control module to the RAM
	typedef struct packed {
		logic      is_store;
		mem_addr_t addr;
		mem_data_t wdata;
		slot_idx_t slot;
	} ram_cmd_t;

endpackage

`default_nettype wire

//--- mem_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_unit_tb import mem_unit_pkg::*; ();

	// ==================================================
	// Test sizes and run limit
	// ==================================================

	localparam int N_FILL = MEM_WORDS;
	localparam int N_RANDOM = 300;
	localparam int N_FULL = 40;
	localparam int N_AFTER = 8;
	localparam int N_TOTAL = 2 * N_FILL + N_RANDOM + N_FULL + NUM_SLOTS + 2 * N_AFTER;
	// Worst case per request, plus room for reset, random gaps and draining
	localparam int WATCHDOG_CYCLES = N_TOTAL * (MEM_LATENCY + 4) * NUM_SLOTS + 1000;

	logic     clk;
	logic     rst;
	logic     req;
	logic     flush;
	mem_req_t req_data;
	logic     ready;
	logic     done;
	mem_res_t done_data;

	integer    seed;
	// Reference memory and the results still owed by the DUT, oldest first
	mem_data_t model_mem [MEM_WORDS];
	mem_res_t  exp_q [$];
	int        pass_cnt;
	int        fail_cnt;
	int        test_errs;
	int        done_cnt;
	logic      saw_full;
	string     cur_test;

	mem_unit_top u_mem_unit_top (
		.clk_i       (clk),
		.rst_i       (rst),
		.req_i       (req),
		.flush_i     (flush),
		.req_data_i  (req_data),
		.ready_o     (ready),
		.done_o      (done),
		.done_data_o (done_data)
	);

	bind mem_unit_top mem_unit_asserts u_asserts (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.flush_i (flush_i),
		.ready_i (ready_o),
		.done_i  (done_o)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ==================================================
	// Checking helpers
	// ==================================================

	task automatic check(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			fail_cnt++;
			test_errs++;
		end else begin
			pass_cnt++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("ERROR in %s: %s", cur_test, msg);
		fail_cnt++;
		test_errs++;
	endtask

	// Inputs change 1 ns after the edge, when ready_o has settled for the cycle
	// Every slot is busy exactly while its result is still owed
	task automatic step();
		@(posedge clk);
		#1;
		check({cur_test, " ready_o"}, 64'(exp_q.size() < NUM_SLOTS), 64'(ready));
		if (!ready) begin
			saw_full = 1'b1;
		end
	endtask

	// Waits for a free slot, then strobes one request and records its result
	task automatic send_req(input logic is_store, input mem_addr_t addr,
		input mem_data_t wdata);
		mem_req_t r;
		mem_res_t e;
		while (!ready) begin
			step();
		end
		r.is_store = is_store;
		r.addr = addr;
		r.wdata = wdata;
		r.tag = mem_tag_t'($random(seed));
		e.is_load = !is_store;
		e.tag = r.tag;
		// Loads see every store accepted before them
		if (is_store) begin
			model_mem[addr] = wdata;
			e.rdata = '0;
		end else begin
			e.rdata = model_mem[addr];
		end
		exp_q.push_back(e);
		req = 1'b1;
		req_data = r;
		step();
		req = 1'b0;
	endtask

	task automatic drain();
		while (exp_q.size() != 0) begin
			step();
		end
		step();
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		$display("Test %s finished with %0d errors", cur_test, test_errs);
	endtask

	// Done pulses are taken in the middle of the cycle
	always @(negedge clk) begin : watch_done
		mem_res_t expected;
		if (rst === 1'b0 && done === 1'b1) begin
			done_cnt++;
			if (exp_q.size() == 0) begin
				note_failure("done_o pulsed with no request outstanding");
			end else begin
				expected = exp_q.pop_front();
				check({cur_test, " done_data_o"}, 64'(expected), 64'(done_data));
			end
		end
		// A flush at the coming edge drops every pending request
		if (rst === 1'b0 && flush === 1'b1) begin
			exp_q.delete();
		end
	end

	// ==================================================
	// Tests
	// ==================================================

	task automatic reset_state();
		start_test("reset_state");
		check({cur_test, " ready_o"}, 64'(1), 64'(ready));
		check({cur_test, " done_o"}, 64'(0), 64'(done));
		// Nothing is pending, so the monitor flags any done here
		repeat (20) step();
		end_test();
	endtask

	task automatic fill_and_read();
		start_test("fill_and_read");
		for (int a = 0; a < N_FILL; a++) begin
			send_req(1'b1, mem_addr_t'(a), $random(seed));
		end
		for (int a = 0; a < N_FILL; a++) begin
			send_req(1'b0, mem_addr_t'(a), '0);
		end
		drain();
		end_test();
	endtask

	task automatic random_mix();
		int   gap;
		logic is_store;
		start_test("random_mix");
		for (int i = 0; i < N_RANDOM; i++) begin
			gap = $random(seed) & 3;
			repeat (gap) step();
			is_store = 1'($random(seed));
			send_req(is_store, mem_addr_t'($random(seed)), $random(seed));
		end
		drain();
		end_test();
	endtask

	task automatic full_occupancy();
		int base;
		start_test("full_occupancy");
		saw_full = 1'b0;
		base = done_cnt;
		for (int i = 0; i < N_FULL; i++) begin
			send_req(1'($random(seed)), mem_addr_t'($random(seed)), $random(seed));
		end
		drain();
		check({cur_test, " ready_o seen low"}, 64'(1), 64'(saw_full));
		check({cur_test, " done count"}, 64'(N_FULL), 64'(done_cnt - base));
		end_test();
	endtask

	task automatic flush_midway();
		int        base;
		mem_addr_t a;
		start_test("flush_midway");
		base = done_cnt;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			send_req(1'b0, mem_addr_t'($random(seed)), '0);
		end
		// Flush right after the first completion, with the next load at the RAM
		while (done_cnt == base) begin
			step();
		end
		flush = 1'b1;
		step();
		flush = 1'b0;
		check({cur_test, " done before flush"}, 64'(1), 64'(done_cnt - base));
		// The stale ack is still on its way while these are accepted
		base = done_cnt;
		for (int i = 0; i < N_AFTER; i++) begin
			a = mem_addr_t'($random(seed));
			send_req(1'b1, a, $random(seed));
			send_req(1'b0, a, '0);
		end
		drain();
		check({cur_test, " done after flush"}, 64'(2 * N_AFTER), 64'(done_cnt - base));
		end_test();
	endtask

	// ==================================================
	// Run control
	// ==================================================

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Run timed out after %0d cycles with requests still pending",
			WATCHDOG_CYCLES);
		$display("Something failed");
		$finish;
	end

	initial begin : main
		seed = 88800;
		pass_cnt = 0;
		fail_cnt = 0;
		test_errs = 0;
		done_cnt = 0;
		saw_full = 1'b0;
		cur_test = "reset";
		rst = 1'b1;
		req = 1'b0;
		flush = 1'b0;
		req_data = '0;
		for (int a = 0; a < MEM_WORDS; a++) begin
			model_mem[a] = '0;
		end
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		reset_state();
		fill_and_read();
		random_mix();
		full_occupancy();
		flush_midway();
		fail_cnt += u_mem_unit_top.u_asserts.err_cnt;
		$display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- mem_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_unit_top import mem_unit_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_i,
	input  logic     req_i,
	input  logic     flush_i,
	input  mem_req_t req_data_i,
	output logic     ready_o,
	output logic     done_o,
	output mem_res_t done_data_o
);

	// ==================================================
	// Internal wiring
	// ==================================================

	slot_state_t          slot_state [NUM_SLOTS];
	mem_req_t             slot_entry [NUM_SLOTS];
	mem_data_t            slot_rdata [NUM_SLOTS];
	logic [NUM_SLOTS-1:0] set_ready;
	logic [NUM_SLOTS-1:0] set_avail;
	logic [NUM_SLOTS-1:0] slot_ack;
	logic                 wr_en;
	logic                 cap_en;
	slot_idx_t            wr_slot;
	slot_idx_t            cap_slot;
	logic                 ram_cmd_valid;
	ram_cmd_t             ram_cmd;
	logic                 ram_ack;
	slot_idx_t            ram_ack_slot;
	mem_data_t            ram_rdata;

	// Control sits in the middle and steers everything else
	mem_slot_ctrl u_ctrl (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.req_i           (req_i),
		.flush_i         (flush_i),
		.ram_ack_i       (ram_ack),
		.ram_ack_slot_i  (ram_ack_slot),
		.slot_state_i    (slot_state),
		.slot_entry_i    (slot_entry),
		.slot_rdata_i    (slot_rdata),
		.set_ready_o     (set_ready),
		.set_avail_o     (set_avail),
		.slot_ack_o      (slot_ack),
		.wr_en_o         (wr_en),
		.cap_en_o        (cap_en),
		.wr_slot_o       (wr_slot),
		.cap_slot_o      (cap_slot),
		.ram_cmd_valid_o (ram_cmd_valid),
		.ram_cmd_o       (ram_cmd),
		.ready_o         (ready_o),
		.done_o          (done_o),
		.done_data_o     (done_data_o)
	);

	// One tracker per slot
	for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_slot
		mem_slot_state u_slot_state (
			.clk_i       (clk_i),
			.rst_i       (rst_i),
			.ack_i       (slot_ack[g]),
			.set_ready_i (set_ready[g]),
			.set_avail_i (set_avail[g]),
			.state_o     (slot_state[g])
		);
	end

	mem_slot_regs u_regs (
		.clk_i      (clk_i),
		.wr_en_i    (wr_en),
		.wr_slot_i  (wr_slot),
		.req_data_i (req_data_i),
		.cap_en_i   (cap_en),
		.cap_slot_i (cap_slot),
		.cap_data_i (ram_rdata),
		.entry_o    (slot_entry),
		.rdata_o    (slot_rdata)
	);

	mem_ram u_ram (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.cmd_valid_i (ram_cmd_valid),
		.cmd_i       (ram_cmd),
		.ack_o       (ram_ack),
		.ack_slot_o  (ram_ack_slot),
		.rdata_o     (ram_rdata)
	);

endmodule

`default_nettype wire

//--- verilog.f
mem_unit_pkg.sv
mem_slot_state.sv
mem_slot_ctrl.sv
mem_slot_regs.sv
mem_ram.sv
mem_unit_top.sv
mem_unit_asserts.sv
mem_unit_tb.sv
